//--- design/cce_msg_pkg.sv
// CCE message unit definitions
`default_nettype none

package cce_msg_pkg;

  // message field widths
  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 64;
  localparam int LCE_ID_W       = 3;
  localparam int WAY_W          = 2;
  localparam int SIZE_W         = 2;
  localparam int BLOCK_OFFSET_W = 6;

  // size code of a whole 64-byte cache block
  localparam logic [SIZE_W-1:0] SIZE_BLOCK = 2'b11;

  // memory commands allowed in flight
  localparam int MEM_MAX_CREDITS = 8;
  localparam int CREDIT_W        = 4;

  // configuration port
  localparam int AXI_ADDR_W = 4;
  localparam int AXI_DATA_W = 32;
  localparam logic [AXI_ADDR_W-1:0] CFG_CTRL_ADDR   = 4'h0;
  localparam logic [AXI_ADDR_W-1:0] CFG_CREDIT_ADDR = 4'h4;
  localparam logic [1:0]            AXI_RESP_OKAY   = 2'b00;

  // CTRL register fields
  localparam int CTRL_EN_BIT = 0;
  localparam int CTRL_ID_LSB = 8;

  typedef enum logic [1:0] {
    e_req_rd    = 2'd0,
    e_req_uc_rd = 2'd1,
    e_req_uc_wr = 2'd2
  } req_type_e;

  typedef enum logic [1:0] {
    e_mem_rd    = 2'd0,
    e_mem_wr    = 2'd1,
    e_mem_uc_rd = 2'd2,
    e_mem_uc_wr = 2'd3
  } mem_type_e;

  typedef enum logic [1:0] {
    e_cmd_data    = 2'd0,
    e_cmd_uc_data = 2'd1,
    e_cmd_uc_done = 2'd2
  } cmd_type_e;

  typedef enum logic [1:0] {
    e_coh_i = 2'd0,
    e_coh_s = 2'd1,
    e_coh_e = 2'd2,
    e_coh_m = 2'd3
  } coh_state_e;

  // same two bits seen as a request type or a memory type
  typedef union packed {
    req_type_e req;
    mem_type_e mem;
  } msg_type_u;

  typedef struct packed {
    msg_type_u            msg_type;
    logic [ADDR_W-1:0]    addr;
    logic [SIZE_W-1:0]    size;
    logic [LCE_ID_W-1:0]  src_id;
    logic [WAY_W-1:0]     way;
    coh_state_e           state;
    logic [DATA_W-1:0]    data;
  } lce_req_s;

  // shared by memory commands and memory responses
  typedef struct packed {
    msg_type_u            msg_type;
    logic [ADDR_W-1:0]    addr;
    logic [SIZE_W-1:0]    size;
    logic [LCE_ID_W-1:0]  lce_id;
    logic [WAY_W-1:0]     way;
    coh_state_e           state;
    logic                 uncached;
    logic [DATA_W-1:0]    data;
  } mem_msg_s;

  typedef struct packed {
    cmd_type_e            msg_type;
    logic [ADDR_W-1:0]    addr;
    logic [SIZE_W-1:0]    size;
    logic [LCE_ID_W-1:0]  dst_id;
    logic [LCE_ID_W-1:0]  src_id;
    logic [WAY_W-1:0]     way;
    coh_state_e           state;
    logic [DATA_W-1:0]    data;
  } lce_cmd_s;

  // software controls handed to the datapath
  typedef struct packed {
    logic                 enable;
    logic [LCE_ID_W-1:0]  cce_id;
    logic [CREDIT_W-1:0]  credit_limit;
  } cfg_s;

endpackage

`default_nettype wire

//--- design/cce_cfg_regs.sv
// CCE configuration registers
`timescale 1ns/1ns
`default_nettype none

module cce_cfg_regs
  (input  wire logic                                 clk_i
   , input  wire logic                               reset_i
   // AXI4-Lite write channels
   , input  wire logic [cce_msg_pkg::AXI_ADDR_W-1:0] s_axil_awaddr_i
   , input  wire logic                               s_axil_awvalid_i
   , output logic                                    s_axil_awready_o
   , input  wire logic [cce_msg_pkg::AXI_DATA_W-1:0] s_axil_wdata_i
   , input  wire logic                               s_axil_wvalid_i
   , output logic                                    s_axil_wready_o
   , output logic                                    s_axil_bvalid_o
   , output logic [1:0]                              s_axil_bresp_o
   , input  wire logic                               s_axil_bready_i
   // AXI4-Lite read channels
   , input  wire logic [cce_msg_pkg::AXI_ADDR_W-1:0] s_axil_araddr_i
   , input  wire logic                               s_axil_arvalid_i
   , output logic                                    s_axil_arready_o
   , output logic                                    s_axil_rvalid_o
   , output logic [cce_msg_pkg::AXI_DATA_W-1:0]      s_axil_rdata_o
   , output logic [1:0]                              s_axil_rresp_o
   , input  wire logic                               s_axil_rready_i
   , output cce_msg_pkg::cfg_s                       cfg_o
   );

  import cce_msg_pkg::*;

  logic                  enable_r;
  logic [LCE_ID_W-1:0]   cce_id_r;
  logic [CREDIT_W-1:0]   credit_limit_r;
  logic [CREDIT_W-1:0]   limit_clamped;
  logic                  bvalid_r;
  logic                  rvalid_r;
  logic [AXI_DATA_W-1:0] rdata_r;
  logic [AXI_DATA_W-1:0] rd_word;
  logic                  wr_accept;
  logic                  rd_accept;

  // take AW and W together, one write at a time until B is taken
  assign wr_accept        = s_axil_awvalid_i && s_axil_wvalid_i && !bvalid_r;
  assign s_axil_awready_o = wr_accept;
  assign s_axil_wready_o  = wr_accept;
  // one read in flight
  assign rd_accept        = s_axil_arvalid_i && !rvalid_r;
  assign s_axil_arready_o = rd_accept;

  // 0 or anything past the hardware maximum means full depth
  always_comb begin
    if (s_axil_wdata_i == '0 || s_axil_wdata_i > AXI_DATA_W'(MEM_MAX_CREDITS)) begin
      limit_clamped = CREDIT_W'(MEM_MAX_CREDITS);
    end else begin
      limit_clamped = s_axil_wdata_i[CREDIT_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_r       <= 1'b0;
      cce_id_r       <= '0;
      credit_limit_r <= CREDIT_W'(MEM_MAX_CREDITS);
    end else if (wr_accept) begin
      if (s_axil_awaddr_i == CFG_CTRL_ADDR) begin
        enable_r <= s_axil_wdata_i[CTRL_EN_BIT];
        cce_id_r <= s_axil_wdata_i[CTRL_ID_LSB +: LCE_ID_W];
      end else if (s_axil_awaddr_i == CFG_CREDIT_ADDR) begin
        credit_limit_r <= limit_clamped;
      end
    end
  end

  // unmapped offsets read as zero
  always_comb begin
    rd_word = '0;
    if (s_axil_araddr_i == CFG_CTRL_ADDR) begin
      rd_word[CTRL_EN_BIT]             = enable_r;
      rd_word[CTRL_ID_LSB +: LCE_ID_W] = cce_id_r;
    end else if (s_axil_araddr_i == CFG_CREDIT_ADDR) begin
      rd_word[CREDIT_W-1:0] = credit_limit_r;
    end
  end

  // response valids held until the master takes them
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_r <= 1'b0;
      rvalid_r <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid_r <= 1'b1;
      end else if (s_axil_bready_i) begin
        bvalid_r <= 1'b0;
      end
      if (rd_accept) begin
        rvalid_r <= 1'b1;
      end else if (s_axil_rready_i) begin
        rvalid_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rdata_r <= rd_word;
    end
  end

  assign s_axil_bvalid_o = bvalid_r;
  assign s_axil_bresp_o  = AXI_RESP_OKAY;
  assign s_axil_rvalid_o = rvalid_r;
  assign s_axil_rdata_o  = rdata_r;
  assign s_axil_rresp_o  = AXI_RESP_OKAY;

  assign cfg_o = '{enable: enable_r, cce_id: cce_id_r, credit_limit: credit_limit_r};

endmodule

`default_nettype wire

//--- design/cce_mem_credits.sv
// Memory command credit counter
`timescale 1ns/1ns
`default_nettype none

module cce_mem_credits
  (input  wire logic                               clk_i
   , input  wire logic                             reset_i
   // command leaves toward memory
   , input  wire logic                             cmd_fire_i
   // response dequeued from memory
   , input  wire logic                             resp_return_i
   , input  wire logic [cce_msg_pkg::CREDIT_W-1:0] credit_limit_i
   , output logic                                  credit_avail_o
   );

  import cce_msg_pkg::*;

  // commands issued and not yet answered
  logic [CREDIT_W-1:0] count_r;

  // a fire and a return in one cycle cancel out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (cmd_fire_i && !resp_return_i) begin
      count_r <= count_r + 1'b1;
    end else if (resp_return_i && !cmd_fire_i) begin
      count_r <= count_r - 1'b1;
    end
  end

  // a lowered limit just stalls until enough responses drain
  assign credit_avail_o = (count_r < credit_limit_i);

  // limit clamping in the register block keeps this in range
  count_max_a: assert property (@(posedge clk_i) disable iff (reset_i)
    count_r <= CREDIT_W'(MEM_MAX_CREDITS));

  // memory answers only what it was sent
  no_underflow_a: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_return_i |-> count_r != '0);

endmodule

`default_nettype wire

//--- design/cce_req_fwd.sv
// LCE request forwarder
`timescale 1ns/1ns
`default_nettype none

module cce_req_fwd
  (input  wire cce_msg_pkg::lce_req_s lce_req_i
   , input  wire logic                lce_req_v_i
   , output logic                     lce_req_yumi_o
   // ready->valid toward memory
   , output cce_msg_pkg::mem_msg_s    mem_cmd_o
   , output logic                     mem_cmd_v_o
   , input  wire logic                mem_cmd_ready_i
   , input  wire logic                credit_avail_i
   , input  wire logic                enable_i
   );

  import cce_msg_pkg::*;

  mem_msg_s mem_cmd;
  logic     type_known;
  logic     fire;

  always_comb begin
    mem_cmd        = '0;
    type_known     = 1'b1;
    // fields common to every request
    mem_cmd.addr   = lce_req_i.addr;
    mem_cmd.size   = lce_req_i.size;
    mem_cmd.lce_id = lce_req_i.src_id;
    mem_cmd.data   = lce_req_i.data;
    case (lce_req_i.msg_type.req)
      e_req_uc_rd: begin
        mem_cmd.msg_type.mem = e_mem_uc_rd;
        mem_cmd.uncached     = 1'b1;
      end
      e_req_uc_wr: begin
        mem_cmd.msg_type.mem = e_mem_uc_wr;
        mem_cmd.uncached     = 1'b1;
      end
      e_req_rd: begin
        // cached fill fetches the whole block from its aligned base
        mem_cmd.msg_type.mem = e_mem_rd;
        mem_cmd.addr  = {lce_req_i.addr[ADDR_W-1:BLOCK_OFFSET_W], BLOCK_OFFSET_W'(0)};
        mem_cmd.size  = SIZE_BLOCK;
        mem_cmd.way   = lce_req_i.way;
        mem_cmd.state = lce_req_i.state;
      end
      default: begin
        // unknown type sits at the head of the queue
        type_known = 1'b0;
      end
    endcase
  end

  // stall on disable, credits or memory back-pressure
  assign fire = lce_req_v_i && type_known && enable_i && credit_avail_i && mem_cmd_ready_i;

  assign mem_cmd_o      = mem_cmd;
  assign mem_cmd_v_o    = fire;
  assign lce_req_yumi_o = fire;

endmodule

`default_nettype wire

//--- design/cce_resp_fwd.sv
// Memory response forwarder
`timescale 1ns/1ns
`default_nettype none

module cce_resp_fwd
  (input  wire cce_msg_pkg::mem_msg_s                   mem_resp_i
   , input  wire logic                                  mem_resp_v_i
   , output logic                                       mem_resp_yumi_o
   // ready->valid toward the LCEs
   , output cce_msg_pkg::lce_cmd_s                      lce_cmd_o
   , output logic                                       lce_cmd_v_o
   , input  wire logic                                  lce_cmd_ready_i
   , input  wire logic [cce_msg_pkg::LCE_ID_W-1:0]      cce_id_i
   );

  import cce_msg_pkg::*;

  lce_cmd_s lce_cmd;
  // response turns into a command
  logic     needs_cmd;
  // response is only consumed
  logic     drop_only;

  always_comb begin
    lce_cmd        = '0;
    needs_cmd      = 1'b0;
    drop_only      = 1'b0;
    lce_cmd.addr   = mem_resp_i.addr;
    // reply goes back to whoever asked
    lce_cmd.dst_id = mem_resp_i.lce_id;
    lce_cmd.src_id = cce_id_i;
    case (mem_resp_i.msg_type.mem)
      e_mem_uc_rd: begin
        needs_cmd        = 1'b1;
        lce_cmd.msg_type = e_cmd_uc_data;
        lce_cmd.size     = mem_resp_i.size;
        lce_cmd.data     = mem_resp_i.data;
      end
      e_mem_uc_wr: begin
        // completion only so size and data stay zero
        needs_cmd        = 1'b1;
        lce_cmd.msg_type = e_cmd_uc_done;
      end
      e_mem_rd: begin
        needs_cmd        = 1'b1;
        lce_cmd.msg_type = e_cmd_data;
        lce_cmd.size     = mem_resp_i.size;
        lce_cmd.data     = mem_resp_i.data;
        lce_cmd.way      = mem_resp_i.way;
        lce_cmd.state    = mem_resp_i.state;
      end
      e_mem_wr: begin
        // writeback ack has no LCE to notify
        drop_only = 1'b1;
      end
    endcase
  end

  // not gated by enable so outstanding traffic always drains
  assign lce_cmd_v_o     = mem_resp_v_i && needs_cmd && lce_cmd_ready_i;
  assign mem_resp_yumi_o = lce_cmd_v_o || (mem_resp_v_i && drop_only);
  assign lce_cmd_o       = lce_cmd;

endmodule

`default_nettype wire

//--- design/cce_msg_top.sv
// CCE message unit top
`timescale 1ns/1ns
`default_nettype none

module cce_msg_top
  (input  wire logic                                 clk_i
   , input  wire logic                               reset_i
   // configuration port
   , input  wire logic [cce_msg_pkg::AXI_ADDR_W-1:0] s_axil_awaddr_i
   , input  wire logic                               s_axil_awvalid_i
   , output logic                                    s_axil_awready_o
   , input  wire logic [cce_msg_pkg::AXI_DATA_W-1:0] s_axil_wdata_i
   , input  wire logic                               s_axil_wvalid_i
   , output logic                                    s_axil_wready_o
   , output logic                                    s_axil_bvalid_o
   , output logic [1:0]                              s_axil_bresp_o
   , input  wire logic                               s_axil_bready_i
   , input  wire logic [cce_msg_pkg::AXI_ADDR_W-1:0] s_axil_araddr_i
   , input  wire logic                               s_axil_arvalid_i
   , output logic                                    s_axil_arready_o
   , output logic                                    s_axil_rvalid_o
   , output logic [cce_msg_pkg::AXI_DATA_W-1:0]      s_axil_rdata_o
   , output logic [1:0]                              s_axil_rresp_o
   , input  wire logic                               s_axil_rready_i
   // LCE side
   , input  wire cce_msg_pkg::lce_req_s              lce_req_i
   , input  wire logic                               lce_req_v_i
   , output logic                                    lce_req_yumi_o
   , output cce_msg_pkg::lce_cmd_s                   lce_cmd_o
   , output logic                                    lce_cmd_v_o
   , input  wire logic                               lce_cmd_ready_i
   // memory side
   , output cce_msg_pkg::mem_msg_s                   mem_cmd_o
   , output logic                                    mem_cmd_v_o
   , input  wire logic                               mem_cmd_ready_i
   , input  wire cce_msg_pkg::mem_msg_s              mem_resp_i
   , input  wire logic                               mem_resp_v_i
   , output logic                                    mem_resp_yumi_o
   );

  import cce_msg_pkg::*;

  cfg_s cfg;
  logic credit_avail;
  logic mem_cmd_fire;

  // handshake completes when memory is ready for a valid command
  assign mem_cmd_fire = mem_cmd_v_o && mem_cmd_ready_i;

  cce_cfg_regs regs
    (.clk_i, .reset_i
     , .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o
     , .s_axil_wdata_i, .s_axil_wvalid_i, .s_axil_wready_o
     , .s_axil_bvalid_o, .s_axil_bresp_o, .s_axil_bready_i
     , .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o
     , .s_axil_rvalid_o, .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rready_i
     , .cfg_o(cfg)
     );

  cce_mem_credits credits
    (.clk_i, .reset_i
     , .cmd_fire_i(mem_cmd_fire)
     , .resp_return_i(mem_resp_yumi_o)
     , .credit_limit_i(cfg.credit_limit)
     , .credit_avail_o(credit_avail)
     );

  cce_req_fwd req_fwd
    (.lce_req_i, .lce_req_v_i, .lce_req_yumi_o
     , .mem_cmd_o, .mem_cmd_v_o, .mem_cmd_ready_i
     , .credit_avail_i(credit_avail)
     , .enable_i(cfg.enable)
     );

  cce_resp_fwd resp_fwd
    (.mem_resp_i, .mem_resp_v_i, .mem_resp_yumi_o
     , .lce_cmd_o, .lce_cmd_v_o, .lce_cmd_ready_i
     , .cce_id_i(cfg.cce_id)
     );

endmodule

`default_nettype wire

//--- dv/cce_msg_tb.sv
// CCE message unit testbench
`timescale 1ns/1ns
`default_nettype none

module cce_msg_tb;

  import cce_msg_pkg::*;

  localparam int SEED        = 26068;
  localparam int N_MIX       = 40;
  localparam int N_CREDIT    = 6;
  localparam int N_AXI       = 6;
  localparam int HOLD_CYCLES = 30;
  // each request and each register access is one transaction
  localparam int N_TXN       = 1 + N_MIX + N_CREDIT + N_AXI;
  localparam int WATCHDOG_NS = 20 * N_TXN * 4;

  logic                  clk_i = 1'b0;
  logic                  reset_i;
  logic [AXI_ADDR_W-1:0] s_axil_awaddr_i;
  logic                  s_axil_awvalid_i;
  logic                  s_axil_awready_o;
  logic [AXI_DATA_W-1:0] s_axil_wdata_i;
  logic                  s_axil_wvalid_i;
  logic                  s_axil_wready_o;
  logic                  s_axil_bvalid_o;
  logic [1:0]            s_axil_bresp_o;
  logic                  s_axil_bready_i;
  logic [AXI_ADDR_W-1:0] s_axil_araddr_i;
  logic                  s_axil_arvalid_i;
  logic                  s_axil_arready_o;
  logic                  s_axil_rvalid_o;
  logic [AXI_DATA_W-1:0] s_axil_rdata_o;
  logic [1:0]            s_axil_rresp_o;
  logic                  s_axil_rready_i;
  lce_req_s              lce_req_i;
  logic                  lce_req_v_i;
  logic                  lce_req_yumi_o;
  lce_cmd_s              lce_cmd_o;
  logic                  lce_cmd_v_o;
  logic                  lce_cmd_ready_i;
  mem_msg_s              mem_cmd_o;
  logic                  mem_cmd_v_o;
  logic                  mem_cmd_ready_i;
  mem_msg_s              mem_resp_i;
  logic                  mem_resp_v_i;
  logic                  mem_resp_yumi_o;

  // register values the DUT should be running with
  logic                  en_exp = 1'b0;
  logic [LCE_ID_W-1:0]   id_exp = '0;
  int                    limit_exp = MEM_MAX_CREDITS;
  // commands sent to memory and not yet answered
  int                    outstanding = 0;
  logic                  hold_resp = 1'b0;
  int                    uc_wr_cnt = 0;
  int                    wb_acks = 0;
  int                    checks = 0;
  int                    errors = 0;

  mem_msg_s              exp_cmd_q[$];
  lce_cmd_s              exp_lce_q[$];
  // memory model pending responses and the cycle each may go out
  mem_msg_s              mem_q[$];
  int                    due_q[$];

  cce_msg_top DUT (.*);

  always #2 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("Mismatch %s exp=%h got=%h", name, exp, got);
    end
  endtask

  // memory command a request should turn into
  function automatic mem_msg_s exp_mem_cmd(input lce_req_s req);
    mem_msg_s m;
    m        = '0;
    m.addr   = req.addr;
    m.size   = req.size;
    m.lce_id = req.src_id;
    m.data   = req.data;
    case (req.msg_type.req)
      e_req_uc_rd: begin
        m.msg_type.mem = e_mem_uc_rd;
        m.uncached     = 1'b1;
      end
      e_req_uc_wr: begin
        m.msg_type.mem = e_mem_uc_wr;
        m.uncached     = 1'b1;
      end
      default: begin
        // cached fill of the whole 64-byte block
        m.msg_type.mem = e_mem_rd;
        m.addr         = req.addr & ~ADDR_W'((1 << BLOCK_OFFSET_W) - 1);
        m.size         = SIZE_BLOCK;
        m.way          = req.way;
        m.state        = req.state;
      end
    endcase
    return m;
  endfunction

  // LCE command a non-writeback response should turn into
  function automatic lce_cmd_s exp_lce_cmd(input mem_msg_s resp,
                                           input logic [LCE_ID_W-1:0] cce_id);
    lce_cmd_s c;
    c        = '0;
    c.addr   = resp.addr;
    c.dst_id = resp.lce_id;
    c.src_id = cce_id;
    case (resp.msg_type.mem)
      e_mem_uc_rd: begin
        c.msg_type = e_cmd_uc_data;
        c.size     = resp.size;
        c.data     = resp.data;
      end
      e_mem_uc_wr: begin
        // done carries no size and no data
        c.msg_type = e_cmd_uc_done;
      end
      default: begin
        c.msg_type = e_cmd_data;
        c.size     = resp.size;
        c.data     = resp.data;
        c.way      = resp.way;
        c.state    = resp.state;
      end
    endcase
    return c;
  endfunction

  function automatic lce_req_s rand_req(input req_type_e t);
    lce_req_s r;
    r.msg_type.req = t;
    r.addr         = $urandom;
    r.size         = SIZE_W'($urandom);
    r.src_id       = LCE_ID_W'($urandom);
    r.way          = WAY_W'($urandom);
    r.state        = coh_state_e'(2'($urandom));
    r.data         = {$urandom, $urandom};
    return r;
  endfunction

  // present one request and hold it until the DUT dequeues it
  task automatic send_req(input lce_req_s req);
    @(posedge clk_i);
    #1;
    lce_req_i   = req;
    lce_req_v_i = 1'b1;
    exp_cmd_q.push_back(exp_mem_cmd(req));
    @(negedge clk_i);
    while (!lce_req_yumi_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    lce_req_v_i = 1'b0;
  endtask

  task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data);
    @(posedge clk_i);
    #1;
    s_axil_awaddr_i  = addr;
    s_axil_awvalid_i = 1'b1;
    s_axil_wdata_i   = data;
    s_axil_wvalid_i  = 1'b1;
    @(negedge clk_i);
    while (!s_axil_awready_o) @(negedge clk_i);
    check_val("s_axil_wready_o", 128'(1'b1), 128'(s_axil_wready_o));
    @(posedge clk_i);
    #1;
    s_axil_awvalid_i = 1'b0;
    s_axil_wvalid_i  = 1'b0;
    s_axil_bready_i  = 1'b1;
    // new value steers the datapath from here on
    if (addr == CFG_CTRL_ADDR) begin
      en_exp = data[0];
      id_exp = data[10:8];
    end else if (addr == CFG_CREDIT_ADDR) begin
      if (data == '0 || data > 32'd8) begin
        limit_exp = MEM_MAX_CREDITS;
      end else begin
        limit_exp = int'(data);
      end
    end
    @(negedge clk_i);
    while (!s_axil_bvalid_o) @(negedge clk_i);
    check_val("s_axil_bresp_o", 128'(2'b00), 128'(s_axil_bresp_o));
    @(posedge clk_i);
    #1;
    s_axil_bready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [AXI_DATA_W-1:0] data);
    @(posedge clk_i);
    #1;
    s_axil_araddr_i  = addr;
    s_axil_arvalid_i = 1'b1;
    @(negedge clk_i);
    while (!s_axil_arready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    s_axil_arvalid_i = 1'b0;
    s_axil_rready_i  = 1'b1;
    @(negedge clk_i);
    while (!s_axil_rvalid_o) @(negedge clk_i);
    data = s_axil_rdata_o;
    check_val("s_axil_rresp_o", 128'(2'b00), 128'(s_axil_rresp_o));
    @(posedge clk_i);
    #1;
    s_axil_rready_i = 1'b0;
  endtask

  // counters only move at the falling edge
  task automatic wait_idle();
    @(posedge clk_i);
    while (outstanding != 0 || exp_lce_q.size() != 0) @(posedge clk_i);
  endtask

  // compare at the falling edge
  // memory model drives after the rising edge
  initial begin : compare_and_memory
    int       cycle;
    logic     taken;
    logic     is_wb;
    logic     exp_v;
    logic     exp_yumi;
    mem_msg_s cmd;
    lce_cmd_s lcmd;
    cycle           = 0;
    taken           = 1'b0;
    mem_resp_i      = '0;
    mem_resp_v_i    = 1'b0;
    mem_cmd_ready_i = 1'b0;
    lce_cmd_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (!reset_i) begin
        // request side stalls on enable, credits and memory ready
        exp_v = lce_req_v_i && en_exp && (outstanding < limit_exp) && mem_cmd_ready_i;
        check_val("lce_req_yumi_o", 128'(exp_v), 128'(lce_req_yumi_o));
        check_val("mem_cmd_v_o", 128'(exp_v), 128'(mem_cmd_v_o));
        if (mem_cmd_v_o) begin
          if (exp_cmd_q.size() == 0) begin
            errors++;
            $display("Memory command issued with no request outstanding");
          end else begin
            cmd = exp_cmd_q.pop_front();
            check_val("mem_cmd_o", 128'(cmd), 128'(mem_cmd_o));
            // memory echoes the command with fresh data
            cmd.data = {$urandom, $urandom};
            if (cmd.msg_type.mem == e_mem_uc_wr) begin
              uc_wr_cnt++;
              // every third write comes back as a writeback ack
              if (uc_wr_cnt % 3 == 0) begin
                cmd.msg_type.mem = e_mem_wr;
                cmd.uncached     = 1'b0;
              end
            end
            if (cmd.msg_type.mem != e_mem_wr) begin
              exp_lce_q.push_back(exp_lce_cmd(cmd, id_exp));
            end
            mem_q.push_back(cmd);
            due_q.push_back(cycle + int'($urandom_range(1, 6)));
          end
        end
        // response side ignores enable
        is_wb    = (mem_resp_i.msg_type.mem == e_mem_wr);
        exp_v    = mem_resp_v_i && !is_wb && lce_cmd_ready_i;
        exp_yumi = mem_resp_v_i && (is_wb || lce_cmd_ready_i);
        check_val("lce_cmd_v_o", 128'(exp_v), 128'(lce_cmd_v_o));
        check_val("mem_resp_yumi_o", 128'(exp_yumi), 128'(mem_resp_yumi_o));
        if (lce_cmd_v_o) begin
          if (exp_lce_q.size() == 0) begin
            errors++;
            $display("LCE command sent with no memory response pending");
          end else begin
            lcmd = exp_lce_q.pop_front();
            check_val("lce_cmd_o", 128'(lcmd), 128'(lce_cmd_o));
          end
        end
        if (mem_resp_yumi_o) begin
          taken = 1'b1;
          outstanding--;
          if (is_wb) begin
            wb_acks++;
          end
        end
        if (mem_cmd_v_o) begin
          outstanding++;
        end
      end
      @(posedge clk_i);
      #1;
      cycle++;
      if (taken && mem_q.size() != 0) begin
        void'(mem_q.pop_front());
        void'(due_q.pop_front());
      end
      taken           = 1'b0;
      mem_cmd_ready_i = ($urandom_range(0, 3) != 0);
      lce_cmd_ready_i = ($urandom_range(0, 2) != 0);
      if (mem_q.size() != 0 && !hold_resp && cycle >= due_q[0]) begin
        mem_resp_i   = mem_q[0];
        mem_resp_v_i = 1'b1;
      end else begin
        mem_resp_v_i = 1'b0;
      end
    end
  end

  initial begin : stimulus
    logic [AXI_DATA_W-1:0] rd;
    void'($urandom(SEED));
    reset_i          = 1'b1;
    lce_req_i        = '0;
    lce_req_v_i      = 1'b0;
    s_axil_awaddr_i  = '0;
    s_axil_awvalid_i = 1'b0;
    s_axil_wdata_i   = '0;
    s_axil_wvalid_i  = 1'b0;
    s_axil_bready_i  = 1'b0;
    s_axil_araddr_i  = '0;
    s_axil_arvalid_i = 1'b0;
    s_axil_rready_i  = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_val("s_axil_bvalid_o", 128'(1'b0), 128'(s_axil_bvalid_o));
    check_val("s_axil_rvalid_o", 128'(1'b0), 128'(s_axil_rvalid_o));

    // request waits at the head until CTRL enables the block, id 5
    fork
      send_req(rand_req(e_req_uc_rd));
      begin
        repeat (6) @(posedge clk_i);
        axi_write(CFG_CTRL_ADDR, 32'h0000_0501);
      end
    join
    axi_read(CFG_CTRL_ADDR, rd);
    check_val("s_axil_rdata_o", 128'(32'h0000_0501), 128'(rd));

    // mixed uncached and cached traffic under random ready stalls
    repeat (N_MIX) begin
      send_req(rand_req(req_type_e'(2'($urandom_range(0, 2)))));
    end
    wait_idle();

    // two credits with memory answers held back
    axi_write(CFG_CREDIT_ADDR, 32'd2);
    axi_read(CFG_CREDIT_ADDR, rd);
    check_val("s_axil_rdata_o", 128'(32'd2), 128'(rd));
    hold_resp = 1'b1;
    fork
      repeat (N_CREDIT) begin
        send_req(rand_req(req_type_e'(2'($urandom_range(0, 2)))));
      end
      begin
        repeat (HOLD_CYCLES) @(posedge clk_i);
        check_val("outstanding_cmds", 128'(2), 128'(outstanding));
        @(negedge clk_i);
        hold_resp = 1'b0;
      end
    join
    wait_idle();

    // zero limit means full depth
    axi_write(CFG_CREDIT_ADDR, 32'd0);
    axi_read(CFG_CREDIT_ADDR, rd);
    check_val("s_axil_rdata_o", 128'(MEM_MAX_CREDITS), 128'(rd));

    check_val("pending_mem_cmds", 128'(0), 128'(exp_cmd_q.size()));
    if (wb_acks == 0) begin
      errors++;
      $display("No writeback response reached the DUT");
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the test sequence finished", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
design/cce_msg_pkg.sv
design/cce_cfg_regs.sv
design/cce_mem_credits.sv
design/cce_req_fwd.sv
design/cce_resp_fwd.sv
design/cce_msg_top.sv
dv/cce_msg_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the CCE message unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module cce_msg_tb -o sim_cce_msg

out=$(./obj_dir/sim_cce_msg 2>&1) || true
echo "$out"

if grep -qx "Regression passed" <<< "$out"; then
  exit 0
fi
exit 1
